//--- sim.f
+incdir+src
src/v2axi_pkg.sv
src/pix_packer.sv
src/line_fifo.sv
src/axis_tx.sv
src/v2axi4s_m.sv
verif/tb_clk_gen.sv
verif/tb_v2axi4s_m.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_v2axi4s_m
FLIST = sim.f

OBJ_DIR = obj_dir
SIM_BIN = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
FAIL    = sim failed
SRCS    = $(shell grep -v '^+' $(FLIST)) src/v2axi_cfg.svh

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "$(FAIL)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL)" $(LOG); then echo "failure found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/tb_v2axi4s_m.sv
// testbench for the video to AXI4-Stream master
// drives random lines through enabled and disabled frames, builds the
// expected word stream from the driven pixels and checks the stream side
// with concurrent assertions

`timescale 1ns/10ps

`include "v2axi_cfg.svh"

module tb_v2axi4s_m
   import v2axi_pkg::*;
();

   localparam int NFRAMES = 4;
   localparam int NLINES  = 13;
   localparam int EOL     = `V2A_AODW;  // model entry {partial, sof, sol, eol, data}
   localparam int SOL     = EOL + 1;
   localparam int SOF     = EOL + 2;
   localparam int PART    = EOL + 3;

   logic                   aclk;
   logic                   aresetn;
   logic                   fstr;
   logic                   vin_en;
   logic                   hstr;
   logic                   hend;
   logic                   href;
   pixel_t                 pdat;
   logic                   tready;
   word_t                  tdata;
   logic                   tvalid;
   logic [`V2A_AUDW-1:0]   tuser;
   logic                   tlast;
   logic                   fifo_nfull;
   logic                   fifo_empty;

   logic [PART:0]          exp_mem [0:1023];
   logic [9:0]             wr_idx;
   logic [9:0]             rd_idx;
   logic [PART:0]          exp_head;
   logic [3:0]             exp_flags;  // {sof, sol, eol, tlast}
   logic                   pending;
   logic                   xfer;
   int                     seed;
   int                     budget = 0;
   int                     errors = 0;
   int                     timeouts = 0;
   int                     n_words;
   logic                   rdy_rand;
   logic                   sof_pend;
   logic                   off_frame;
   int                     line_len [0:NLINES-1];
   int                     line_gap [0:NLINES-1];
   int                     frame_lines [0:NFRAMES-1] = '{3, 2, 4, 4};
   logic                   frame_en [0:NFRAMES-1] = '{1'b1, 1'b0, 1'b1, 1'b1};

   tb_clk_gen clk_gen0 (
      .o_aclk    (aclk),
      .o_aresetn (aresetn)
   );

   v2axi4s_m dut0 (
      .aclk         (aclk),
      .aresetn      (aresetn),
      .i_fstr       (fstr),
      .i_vin_en     (vin_en),
      .i_hstr       (hstr),
      .i_hend       (hend),
      .i_href       (href),
      .i_pdat       (pdat),
      .tready       (tready),
      .tdata        (tdata),
      .tvalid       (tvalid),
      .tuser        (tuser),
      .tlast        (tlast),
      .o_fifo_nfull (fifo_nfull),
      .o_fifo_empty (fifo_empty)
   );

   // ------------------------------
   // reference model head and checks
   // ------------------------------
   assign exp_head  = exp_mem[rd_idx];
   assign exp_flags = {exp_head[SOF], exp_head[SOL], exp_head[EOL], exp_head[EOL]};
   assign pending   = (wr_idx != rd_idx);
   assign xfer      = tvalid & tready;

   function automatic void report_mismatch(input string name, input word_t exp, input word_t act);
      errors++;
      $display("Error: %s expected %0h actual %0h", name, exp, act);
   endfunction

   function automatic void report_fault(input string msg);
      errors++;
      $display("%s", msg);
   endfunction

   a_packing : assert property (@(posedge aclk) disable iff (!aresetn)
      xfer && pending && !exp_head[PART] |-> tdata == exp_head[`V2A_AODW-1:0])
      else report_mismatch("packing", $sampled(exp_head[`V2A_AODW-1:0]), $sampled(tdata));

   a_partial : assert property (@(posedge aclk) disable iff (!aresetn)
      xfer && pending && exp_head[PART] |-> tdata == exp_head[`V2A_AODW-1:0])
      else report_mismatch("partial", $sampled(exp_head[`V2A_AODW-1:0]), $sampled(tdata));

   a_line_flags : assert property (@(posedge aclk) disable iff (!aresetn)
      xfer && pending |-> {tuser[1:0], tlast} == exp_flags[2:0])
      else report_mismatch("line_flags", word_t'($sampled(exp_flags[2:0])),
                           word_t'($sampled({tuser[1:0], tlast})));

   a_frame_start : assert property (@(posedge aclk) disable iff (!aresetn)
      xfer && pending |-> tuser[2] == exp_flags[3])
      else report_mismatch("frame_start", word_t'($sampled(exp_flags[3])),
                           word_t'($sampled(tuser[2])));

   a_no_extra : assert property (@(posedge aclk) disable iff (!aresetn) xfer |-> pending)
      else report_fault("stream sent a word that no driven pixel accounts for");

   a_hold : assert property (@(posedge aclk) disable iff (!aresetn)
      tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tuser) && $stable(tlast))
      else report_fault("stream word changed or dropped while tready was low");

   a_gating : assert property (@(posedge aclk) disable iff (!aresetn)
      off_frame |-> fifo_empty && !tvalid)
      else report_fault("disabled frame let words into the FIFO or the stream");

   a_reset : assert property (@(posedge aclk)
      $rose(aresetn) |-> !tvalid && !tlast && fifo_empty && !fifo_nfull)
      else report_fault("outputs were not idle right after reset");

   always @(posedge aclk) begin
      if (!aresetn) begin
         rd_idx  <= '0;
         n_words <= 0;
      end else if (xfer && pending) begin
         rd_idx  <= rd_idx + 10'd1;                // word consumed by the sink
         n_words <= n_words + 1;
      end
   end

   // ------------------------------
   // stimulus helpers
   // ------------------------------
   function automatic int rand_range(input int lo, input int hi);
      int r;
      r = $random(seed) & 32'h7fff_ffff;
      return lo + r % (hi - lo + 1);
   endfunction

   task automatic next_cycle();
      int r;
      @(posedge aclk);
      r = $random(seed);
      tready <= rdy_rand ? r[1] : 1'b1;
   endtask

   task automatic add_expected(input word_t w, input logic sol, input logic eol,
                               input logic part);
      exp_mem[wr_idx] <= {part, sof_pend, sol, eol, w};
      wr_idx          <= wr_idx + 10'd1;
      sof_pend = 1'b0;                             // only the first word of a frame
   endtask

   task automatic wait_drain();
      next_cycle();
      while (pending) next_cycle();
   endtask

   task automatic start_frame(input logic en, input logic rand_rdy);
      wait_drain();                                // flush would drop words still queued
      rdy_rand = rand_rdy;
      sof_pend = en;
      fstr      <= 1'b1;
      vin_en    <= en;
      off_frame <= ~en;
      next_cycle();
      fstr   <= 1'b0;
      vin_en <= 1'b0;
   endtask

   task automatic drive_line(input int len, input int gap, input logic en);
      int       i;
      int       slot;
      pixel_t   px;
      word_t    acc;
      logic     sol;
      i = 0;
      slot = 0;
      acc = '0;
      sol = 1'b1;
      next_cycle();
      hstr <= 1'b1;
      while (i < len) begin
         next_cycle();
         hstr <= 1'b0;
         if (fifo_nfull) begin
            href <= 1'b0;                          // pause the line
            hend <= 1'b0;
         end else begin
            px = pixel_t'($random(seed));
            href <= 1'b1;
            hend <= (i == len - 1);
            pdat <= px;
            acc = acc | (word_t'(px) << (slot * `V2A_PXDW));
            if (slot == `V2A_PX_PER_WORD - 1 || i == len - 1) begin
               if (en) add_expected(acc, sol, i == len - 1, slot != `V2A_PX_PER_WORD - 1);
               sol = 1'b0;
               acc = '0;
               slot = 0;
            end else begin
               slot++;
            end
            i++;
         end
      end
      next_cycle();
      href <= 1'b0;
      hend <= 1'b0;
      repeat (gap) next_cycle();
   endtask

   task automatic finish_run();
      $display("checked %0d words, %0d errors, %0d timeouts", n_words, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   endtask

   // ------------------------------
   // test sequence
   // ------------------------------
   initial begin : stimulus
      int f;
      int n;
      int ln;
      int total;
      seed = 32'hdbd0;
      fstr = 1'b0;
      vin_en = 1'b0;
      hstr = 1'b0;
      hend = 1'b0;
      href = 1'b0;
      pdat = '0;
      tready = 1'b1;
      wr_idx = '0;
      rdy_rand = 1'b0;
      sof_pend = 1'b0;
      off_frame = 1'b0;
      total = 0;
      for (n = 0; n < NLINES; n++) begin
         line_len[n] = rand_range(8, 30);
         if (n == 1 && line_len[n] % 4 == 0) line_len[n]++;   // at least one partial word
         line_gap[n] = rand_range(2, 10);
         total += line_len[n] + line_gap[n];
      end
      budget = total;
      next_cycle();
      while (!aresetn) next_cycle();
      ln = 0;
      for (f = 0; f < NFRAMES; f++) begin
         start_frame(frame_en[f], f >= 2);         // back-pressure from frame 2 on
         for (n = 0; n < frame_lines[f]; n++) begin
            drive_line(line_len[ln], line_gap[ln], frame_en[f]);
            ln++;
         end
      end
      wait_drain();
      repeat (4) next_cycle();
      finish_run();
   end

   initial begin : watchdog
      wait (budget > 0);
      #(budget * 8 * 100);
      timeouts++;
      $display("watchdog expired after %0d ns with %0d words outstanding", budget * 800,
               wr_idx - rd_idx);
      finish_run();
   end

endmodule

//--- verif/tb_clk_gen.sv
// testbench clock and reset
// 100 ns clock, synchronous active low reset held for 8 cycles

`timescale 1ns/10ps

module tb_clk_gen (
   output logic   o_aclk,
   output logic   o_aresetn
);

   initial begin
      o_aclk = 1'b0;
      forever #50 o_aclk = ~o_aclk;     // 100 ns period
   end

   initial begin
      o_aresetn = 1'b0;
      repeat (8) @(posedge o_aclk);
      o_aresetn <= 1'b1;
   end

endmodule

//--- src/v2axi4s_m.sv
// video to AXI4-Stream master
// native video input (strobes, line reference, 8-bit pixel per clock)
// packed four pixels per 32-bit word and sent as an AXI4-Stream

`timescale 1ns/10ps

`include "v2axi_cfg.svh"

module v2axi4s_m
   import v2axi_pkg::*;
(
   input  logic                   aclk,
   input  logic                   aresetn,
   // native video input
   input  logic                   i_fstr,
   input  logic                   i_vin_en,
   input  logic                   i_hstr,
   input  logic                   i_hend,
   input  logic                   i_href,
   input  pixel_t                 i_pdat,
   // AXI4-Stream master
   input  logic                   tready,
   output word_t                  tdata,
   output logic                   tvalid,
   output logic [`V2A_AUDW-1:0]   tuser,      // {sof, sol, eol}
   output logic                   tlast,
   // FIFO status
   output logic                   o_fifo_nfull,
   output logic                   o_fifo_empty
);

   logic          push;
   fifo_entry_t   wdata;
   logic          pop;
   fifo_entry_t   rdata;

   pix_packer u_packer (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .i_fstr   (i_fstr),
      .i_vin_en (i_vin_en),
      .i_hstr   (i_hstr),
      .i_hend   (i_hend),
      .i_href   (i_href),
      .i_pdat   (i_pdat),
      .o_push   (push),
      .o_wdata  (wdata)
   );

   // flushed at every frame start
   line_fifo u_fifo (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .i_push   (push),
      .i_wdata  (wdata),
      .i_pop    (pop),
      .i_flush  (i_fstr),
      .o_rdata  (rdata),
      .o_empty  (o_fifo_empty),
      .o_nfull  (o_fifo_nfull)
   );

   axis_tx u_tx (
      .aclk         (aclk),
      .aresetn      (aresetn),
      .i_fifo_empty (o_fifo_empty),
      .i_rdata      (rdata),
      .i_fstr       (i_fstr),
      .i_tready     (tready),
      .o_pop        (pop),
      .o_tdata      (tdata),
      .o_tvalid     (tvalid),
      .o_tuser      (tuser),
      .o_tlast      (tlast)
   );

endmodule

//--- src/axis_tx.sv
// AXI4-Stream transmitter
// pops the line FIFO while the sink is ready, parks late read data in a
// two-entry skid queue, and rebuilds tuser {sof, sol, eol} and tlast
// from the line sync marker of each entry

`timescale 1ns/10ps

`include "v2axi_cfg.svh"

module axis_tx
   import v2axi_pkg::*;
(
   input  logic                   aclk,
   input  logic                   aresetn,
   input  logic                   i_fifo_empty,
   input  fifo_entry_t            i_rdata,     // valid one cycle after o_pop
   input  logic                   i_fstr,      // frame start, arms sof
   input  logic                   i_tready,
   output logic                   o_pop,
   output word_t                  o_tdata,
   output logic                   o_tvalid,
   output logic [`V2A_AUDW-1:0]   o_tuser,     // {sof, sol, eol}
   output logic                   o_tlast
);

   logic          rd_vld;              // i_rdata valid this cycle
   fifo_entry_t   q_dat [0:1];         // skid queue, head at 0
   logic [1:0]    q_cnt;               // queue occupancy
   logic          q_wr_idx;
   logic          deq;
   logic          enq;
   logic          load;                // output register free or draining
   logic          src_vld;
   fifo_entry_t   src_dat;
   logic          src_mark;
   word_t         tdata_r;
   logic          tvalid_r;
   logic          sof_arm;             // next word starts a frame
   logic          sof_r;
   logic          sol_r;
   logic          eol_r;
   line_state_t   line_st;

   // ------------------------------
   // FIFO read
   // ------------------------------
   assign o_pop = ~i_fifo_empty & i_tready;

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         rd_vld <= 1'b0;
      end else begin
         rd_vld <= o_pop;
      end
   end

   // ------------------------------
   // skid queue
   // ------------------------------
   assign load     = ~tvalid_r | i_tready;
   assign src_vld  = (q_cnt != 2'd0) | rd_vld;
   assign src_dat  = (q_cnt != 2'd0) ? q_dat[0] : i_rdata;   // queue first, keeps order
   assign src_mark = src_dat[`V2A_AODW];

   assign deq      = load & (q_cnt != 2'd0);
   assign enq      = rd_vld & ~(load & (q_cnt == 2'd0));       // bypass when both idle
   assign q_wr_idx = (q_cnt == 2'd2) | ((q_cnt == 2'd1) & ~deq);

   always_ff @(posedge aclk) begin
      if (deq) begin
         q_dat[0] <= q_dat[1];
      end
      if (enq) begin
         q_dat[q_wr_idx] <= i_rdata;   // overrides the shift when it lands on 0
      end
   end

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         q_cnt <= 2'd0;
      end else if (enq & ~deq) begin
         q_cnt <= q_cnt + 2'd1;
      end else if (deq & ~enq) begin
         q_cnt <= q_cnt - 2'd1;
      end
   end

   // ------------------------------
   // stream output register
   // ------------------------------
   always_ff @(posedge aclk) begin
      if (load & src_vld) begin
         tdata_r <= src_dat[`V2A_AODW-1:0];
      end
   end

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         tvalid_r <= 1'b0;
         sof_r    <= 1'b0;
         sol_r    <= 1'b0;
         eol_r    <= 1'b0;
         sof_arm  <= 1'b0;
         line_st  <= LINE_IDLE;
      end else begin
         sof_arm <= i_fstr | (sof_arm & ~(load & src_vld));

         // flags travel with the word, cleared when the register drains
         if (load) begin
            tvalid_r <= src_vld;
            sof_r    <= src_vld & sof_arm;
            sol_r    <= src_vld & src_mark & (line_st == LINE_IDLE);
            eol_r    <= src_vld & src_mark & (line_st == LINE_ACTIVE);
         end

         // a marked word opens a line when idle, closes it when active
         if (i_fstr) begin
            line_st <= LINE_IDLE;
         end else if (load & src_vld & src_mark) begin
            case (line_st)
               LINE_IDLE:   line_st <= LINE_ACTIVE;
               LINE_ACTIVE: line_st <= LINE_IDLE;
               default:     line_st <= LINE_IDLE;
            endcase
         end
      end
   end

   assign o_tdata  = tdata_r;
   assign o_tvalid = tvalid_r;
   assign o_tuser  = {sof_r, sol_r, eol_r};
   assign o_tlast  = eol_r;                 // one line per packet

endmodule

//--- src/line_fifo.sv
// line FIFO
// single clock FIFO between packer and stream transmitter, registered read
// port with one cycle latency, flush at frame start, near-full and empty flags

`timescale 1ns/10ps

`include "v2axi_cfg.svh"

module line_fifo
   import v2axi_pkg::*;
(
   input  logic          aclk,
   input  logic          aresetn,
   input  logic          i_push,      // write strobe
   input  fifo_entry_t   i_wdata,
   input  logic          i_pop,       // only while not empty
   input  logic          i_flush,     // drop all entries at next edge
   output fifo_entry_t   o_rdata,     // valid one cycle after i_pop
   output logic          o_empty,
   output logic          o_nfull      // two or fewer free entries
);

   fifo_entry_t   mem [0:`V2A_FIFO_DEP-1];
   fifo_addr_t    wptr;               // write pointer, msb wraps
   fifo_addr_t    rptr;               // read pointer, msb wraps
   fifo_addr_t    level;              // entries held
   fifo_entry_t   rdata_r;

   // ------------------------------
   // storage
   // ------------------------------
   always_ff @(posedge aclk) begin
      if (i_push) begin
         mem[wptr[`V2A_FIFO_AW-1:0]] <= i_wdata;
      end
   end

   always_ff @(posedge aclk) begin
      if (i_pop) begin
         rdata_r <= mem[rptr[`V2A_FIFO_AW-1:0]];
      end
   end

   assign o_rdata = rdata_r;

   // ------------------------------
   // pointers
   // ------------------------------
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         wptr <= '0;
         rptr <= '0;
      end else if (i_flush) begin
         wptr <= '0;                      // frame start, restart empty
         rptr <= '0;
      end else begin
         if (i_push) begin
            wptr <= wptr + 1'b1;
         end
         if (i_pop) begin
            rptr <= rptr + 1'b1;
         end
      end
   end

   // ------------------------------
   // status flags
   // ------------------------------
   assign level   = wptr - rptr;
   assign o_empty = (wptr == rptr);

   // one push may already be in flight from the packer when the source sees this
   assign o_nfull = (level >= fifo_addr_t'(`V2A_FIFO_DEP - 2));

endmodule

//--- src/pix_packer.sv
// pixel packer
// gathers four pixels per word with P0 in the low byte, closes a partial
// word at line end with zero high bytes, and tags the first and last word
// of each line with a sync marker before pushing into the line FIFO

`timescale 1ns/10ps

`include "v2axi_cfg.svh"

module pix_packer
   import v2axi_pkg::*;
(
   input  logic          aclk,
   input  logic          aresetn,
   input  logic          i_fstr,      // frame start pulse
   input  logic          i_vin_en,    // frame enable, sampled at i_fstr
   input  logic          i_hstr,      // pulse before first i_href of a line
   input  logic          i_hend,      // same cycle as last i_href
   input  logic          i_href,      // pixel valid
   input  pixel_t        i_pdat,
   output logic          o_push,      // one-cycle write strobe
   output fifo_entry_t   o_wdata      // {marker, word}
);

   logic          fm_vin_en;          // frame input enable
   pkt_cnt_t      pkt_cnt;            // slot of the next pixel in the word
   logic          hsyn_mark;          // line sync marker, hstr or hend seen
   word_t         px_que;             // word under assembly
   word_t         px_shift;           // word with current pixel shifted in
   logic [4:0]    fill_sh;            // right shift to close a partial word
   logic          word_end;           // last pixel of a word or of a line

   // ------------------------------
   // packing datapath
   // ------------------------------

   // new pixel enters at the top, older pixels move down
   assign px_shift = {i_pdat, px_que[`V2A_AODW-1:`V2A_PXDW]};

   // slot 3 needs no shift, slot 0 leaves one pixel that must drop 3 bytes
   assign fill_sh  = {~pkt_cnt, 3'b000};

   assign word_end = (i_href & (pkt_cnt == pkt_cnt_t'(`V2A_PX_PER_WORD - 1))) | i_hend;

   always_ff @(posedge aclk) begin
      if (i_hend) begin
         px_que <= px_shift >> fill_sh;    // zero fill from the top
      end else if (i_href) begin
         px_que <= px_shift;
      end
   end

   // ------------------------------
   // control
   // ------------------------------
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         fm_vin_en <= 1'b0;
         pkt_cnt   <= '0;
         hsyn_mark <= 1'b0;
         o_push    <= 1'b0;
      end else begin
         // enable decided once per frame
         if (i_fstr) begin
            fm_vin_en <= i_vin_en;
         end

         // slot counter wraps every four pixels, restarts each line
         if (i_hend) begin
            pkt_cnt <= '0;
         end else if (i_href) begin
            pkt_cnt <= pkt_cnt + 2'd1;
         end

         // set at line start or end, held until the word carrying it is pushed
         hsyn_mark <= i_hstr | i_hend | (hsyn_mark & ~o_push);

         o_push <= word_end & fm_vin_en;
      end
   end

   // marker rides in the top bit of the entry
   assign o_wdata = {hsyn_mark, px_que};

endmodule

//--- src/v2axi_pkg.sv
// shared types for the video to AXI4-Stream bridge
// pixel, word and FIFO entry vectors, FIFO pointer and packing slot,
// and the line tracking state of the stream transmitter

`include "v2axi_cfg.svh"

package v2axi_pkg;

   // ------------------------------
   // data vectors
   // ------------------------------
   typedef logic [`V2A_PXDW-1:0]     pixel_t;       // one input pixel
   typedef logic [`V2A_AODW-1:0]     word_t;        // one packed stream word

   // word plus line sync marker in the msb
   typedef logic [`V2A_AODW:0]       fifo_entry_t;

   // ------------------------------
   // control vectors
   // ------------------------------
   typedef logic [`V2A_FIFO_AW:0]    fifo_addr_t;   // msb is the wrap bit
   typedef logic [1:0]               pkt_cnt_t;     // pixel slot within a word

   typedef enum logic {
      LINE_IDLE   = 1'b0,    // waiting for first word of a line
      LINE_ACTIVE = 1'b1     // inside a line, next marker ends it
   } line_state_t;

endpackage

//--- src/v2axi_cfg.svh
// video to AXI4-Stream bridge configuration
// fixed packing of four 8-bit pixels into one 32-bit stream word
// and the depth of the line FIFO between packer and transmitter

`ifndef V2AXI_CFG_SVH
`define V2AXI_CFG_SVH

// ------------------------------
// data path widths
// ------------------------------
`define V2A_PXDW          8     // pixel width
`define V2A_AODW          32    // tdata width
`define V2A_PX_PER_WORD   4     // pixels packed per word
`define V2A_AUDW          3     // tuser {sof, sol, eol}

// ------------------------------
// line FIFO
// ------------------------------
`define V2A_FIFO_DEP      8     // entries, power of two
`define V2A_FIFO_AW       3     // log2 of depth

`endif
